//--- hdl/pov_pkg.sv
`default_nettype none

package pov_pkg;

    // Each half turn between two Hall tops is split into this many slices
    localparam int SLICES_PER_HALF_TURN = 128;

    // A full turn covers both half turns
    localparam int NUM_SLICES = 2 * SLICES_PER_HALF_TURN;

    // Widest LED column that the datapath can carry
    localparam int MAX_LEDS = 64;

    // Slice number over a full turn
    // Values 0 to 127 follow hall_1 and values 128 to 255 follow hall_2
    typedef logic [$clog2(NUM_SLICES)-1:0] slice_t;

    // Rotation speed in turns per second
    typedef logic [15:0] speed_t;

    // One LED column, bit i drives LED i
    // Only the low NUM_LEDS bits reach the LED drivers
    typedef logic [MAX_LEDS-1:0] led_col_t;

endpackage

`default_nettype wire

//--- hdl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // Access type of one frame memory transfer
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // Command that a requester holds stable until its ack rises
    typedef struct packed {
        mem_op_e            op;
        pov_pkg::slice_t    addr;
        pov_pkg::led_col_t  wdata;
    } mem_req_t;

    // Request side of one arbiter port
    // The ack and the read data come back on separate signals
    typedef struct packed {
        logic     req;
        mem_req_t cmd;
    } mem_port_t;

endpackage

`default_nettype wire

//--- hdl/hall_sensor.sv
`default_nettype none

module hall_sensor #(
    parameter int CLK_HZ = 66000000
) (
    input  wire              clk,
    input  wire              nrst,
    input  wire              hall_1,
    input  wire              hall_2,
    output pov_pkg::slice_t  slice_cnt,
    output logic             position_sync,
    output pov_pkg::speed_t  speed_data
);
    import pov_pkg::*;

    localparam int SLICE_BITS = $clog2(SLICES_PER_HALF_TURN);
    localparam int COUNT_BITS = 32;
    // The slice period is the half-turn length shifted down by SLICE_BITS
    localparam int PERIOD_BITS = COUNT_BITS - SLICE_BITS;
    localparam logic [COUNT_BITS:0] CLK_HZ_W = (COUNT_BITS + 1)'(CLK_HZ);
    localparam logic [SLICE_BITS-1:0] LAST_SLICE = SLICE_BITS'(SLICES_PER_HALF_TURN - 1);

    // Half turn 1 follows hall_1, half turn 2 follows hall_2
    typedef enum logic {
        HALF_1,
        HALF_2
    } half_e;

    half_e                  half_turn;
    logic                   guard;
    logic                   top;
    logic [COUNT_BITS-1:0]  turn_count;
    logic [COUNT_BITS-1:0]  half_turn_len;
    logic                   speed_due;
    logic [PERIOD_BITS-1:0] slice_period;
    logic [PERIOD_BITS-1:0] slice_timer;
    logic [SLICE_BITS-1:0]  slice_half_cnt;

    // First cycle of a low sensor while no earlier top is still guarded
    assign top = (!hall_1 || !hall_2) && !guard;

    // The guard holds off further tops until both sensors read high again
    // Bounces on one sensor therefore collapse into a single top
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            guard     <= 1'b0;
            half_turn <= HALF_1;
        end else if (top) begin
            guard     <= 1'b1;
            half_turn <= (!hall_1) ? HALF_1 : HALF_2;
        end else if (hall_1 && hall_2) begin
            guard <= 1'b0;
        end
    end

    // Cycle count since the previous top, restarted at 1 on every top
    // so that it equals the half-turn length in the next top cycle
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            turn_count    <= '0;
            half_turn_len <= '0;
            slice_period  <= '0;
            speed_due     <= 1'b0;
        end else begin
            speed_due <= top;
            if (top) begin
                half_turn_len <= turn_count;
                slice_period  <= PERIOD_BITS'(turn_count >> SLICE_BITS);
                turn_count    <= COUNT_BITS'(1);
            end else if (turn_count != '1) begin
                // Saturate while the rotor is stopped
                turn_count <= turn_count + 1'b1;
            end
        end
    end

    // Speed is the clock rate over the full-turn length, one cycle after
    // the half-turn length is captured
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            speed_data <= '0;
        end else if (speed_due) begin
            if (half_turn_len == '0) begin
                speed_data <= '0;
            end else begin
                speed_data <= speed_t'(CLK_HZ_W / {half_turn_len, 1'b0});
            end
        end
    end

    // Slice pacing restarts at every top, which gives the first pulse
    // Later pulses come every slice_period cycles, up to the last slice
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            position_sync  <= 1'b0;
            slice_timer    <= '0;
            slice_half_cnt <= '0;
        end else begin
            position_sync <= 1'b0;
            if (top) begin
                position_sync  <= 1'b1;
                slice_timer    <= '0;
                slice_half_cnt <= '0;
            end else if (slice_period != '0 && slice_timer == slice_period - 1'b1 &&
                         slice_half_cnt != LAST_SLICE) begin
                position_sync  <= 1'b1;
                slice_timer    <= '0;
                slice_half_cnt <= slice_half_cnt + 1'b1;
            end else begin
                slice_timer <= slice_timer + 1'b1;
            end
        end
    end

    // The half-turn flag becomes the top bit of the full-turn slice number
    assign slice_cnt = {half_turn == HALF_2, slice_half_cnt};

endmodule

`default_nettype wire

//--- hdl/column_streamer.sv
`default_nettype none

module column_streamer #(
    parameter int NUM_LEDS = 16
) (
    input  wire                 clk,
    input  wire                 nrst,
    input  wire pov_pkg::slice_t   slice_cnt,
    input  wire                 position_sync,
    input  wire                 mem_ack,
    input  wire pov_pkg::led_col_t mem_rdata,
    output mem_pkg::mem_port_t  mem_port,
    output logic                led_sdo,
    output logic                led_sclk,
    output logic                led_latch
);
    import pov_pkg::*;
    import mem_pkg::*;

    localparam int BIT_W = (NUM_LEDS > 1) ? $clog2(NUM_LEDS) : 1;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQ,
        FETCH_DROP
    } fetch_state_e;

    typedef enum logic [1:0] {
        SHIFT_IDLE,
        SHIFT_LOW,
        SHIFT_HIGH,
        SHIFT_LATCH
    } shift_state_e;

    fetch_state_e     fetch_state;
    shift_state_e     shift_state;
    logic             pend_valid;
    slice_t           pend_slice;
    logic             fetch_req;
    slice_t           fetch_addr;
    logic             fetch_valid;
    led_col_t         fetch_buf;
    led_col_t         shift_buf;
    logic [BIT_W-1:0] bit_idx;
    logic             fetch_start;
    logic             buf_move;

    // A fetch starts only into an empty fetch buffer
    assign fetch_start = (fetch_state == FETCH_IDLE) && pend_valid && !fetch_valid;
    assign buf_move    = (shift_state == SHIFT_IDLE) && fetch_valid;

    // The newest slice overwrites a slice whose fetch has not started
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pend_valid <= 1'b0;
            pend_slice <= '0;
        end else if (position_sync) begin
            pend_valid <= 1'b1;
            pend_slice <= slice_cnt;
        end else if (fetch_start) begin
            pend_valid <= 1'b0;
        end
    end

    // Four-phase read, waiting for ack to fall before the next request
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            fetch_state <= FETCH_IDLE;
            fetch_req   <= 1'b0;
            fetch_addr  <= '0;
            fetch_valid <= 1'b0;
        end else begin
            if (buf_move) begin
                fetch_valid <= 1'b0;
            end
            case (fetch_state)
                FETCH_IDLE: begin
                    if (fetch_start) begin
                        fetch_req   <= 1'b1;
                        fetch_addr  <= pend_slice;
                        fetch_state <= FETCH_REQ;
                    end
                end
                FETCH_REQ: begin
                    if (mem_ack) begin
                        fetch_req   <= 1'b0;
                        fetch_valid <= 1'b1;
                        fetch_state <= FETCH_DROP;
                    end
                end
                FETCH_DROP: begin
                    if (!mem_ack) begin
                        fetch_state <= FETCH_IDLE;
                    end
                end
                default: fetch_state <= FETCH_IDLE;
            endcase
        end
    end

    // Column data moves from the memory to the fetch buffer, then on
    always_ff @(posedge clk) begin
        if (fetch_state == FETCH_REQ && mem_ack) begin
            fetch_buf <= mem_rdata;
        end
        if (buf_move) begin
            shift_buf <= fetch_buf;
        end
    end

    // Two cycles per bit, highest LED first, then one latch cycle
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            shift_state <= SHIFT_IDLE;
            bit_idx     <= '0;
        end else begin
            case (shift_state)
                SHIFT_IDLE: begin
                    if (buf_move) begin
                        bit_idx     <= BIT_W'(NUM_LEDS - 1);
                        shift_state <= SHIFT_LOW;
                    end
                end
                SHIFT_LOW: shift_state <= SHIFT_HIGH;
                SHIFT_HIGH: begin
                    if (bit_idx == '0) begin
                        shift_state <= SHIFT_LATCH;
                    end else begin
                        bit_idx     <= bit_idx - 1'b1;
                        shift_state <= SHIFT_LOW;
                    end
                end
                default: shift_state <= SHIFT_IDLE;
            endcase
        end
    end

    // bit_idx only changes after the high phase, so led_sdo is stable
    // across the rising edge of led_sclk
    assign led_sclk  = (shift_state == SHIFT_HIGH);
    assign led_latch = (shift_state == SHIFT_LATCH);
    assign led_sdo   = (shift_state == SHIFT_LOW || shift_state == SHIFT_HIGH) &&
                       shift_buf[bit_idx];

    always_comb begin
        mem_port.req       = fetch_req;
        mem_port.cmd.op    = MEM_READ;
        mem_port.cmd.addr  = fetch_addr;
        mem_port.cmd.wdata = '0;
    end

endmodule

`default_nettype wire

//--- hdl/mem_arbiter.sv
`default_nettype none

module mem_arbiter (
    input  wire                    clk,
    input  wire                    nrst,
    input  wire mem_pkg::mem_port_t stream_port,
    input  wire mem_pkg::mem_port_t host_port,
    input  wire pov_pkg::led_col_t ram_rdata,
    output logic                   stream_ack,
    output pov_pkg::led_col_t      stream_rdata,
    output logic                   host_ack,
    output pov_pkg::led_col_t      host_rdata,
    output logic                   ram_en,
    output logic                   ram_we,
    output pov_pkg::slice_t        ram_addr,
    output pov_pkg::led_col_t      ram_wdata
);
    import pov_pkg::*;
    import mem_pkg::*;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ACCESS,
        ARB_ACK,
        ARB_RELEASE
    } arb_state_e;

    arb_state_e state;
    logic       grant_host;
    led_col_t   rdata_q;
    mem_port_t  owner_port;

    // Request of the port that holds the grant
    assign owner_port = grant_host ? host_port : stream_port;

    // ACCESS drives the RAM, ACK takes its data and raises ack,
    // RELEASE waits for the owner to drop req
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state      <= ARB_IDLE;
            grant_host <= 1'b0;
            stream_ack <= 1'b0;
            host_ack   <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    // The streamer wins a tie so that the display never stalls
                    if (stream_port.req) begin
                        grant_host <= 1'b0;
                        state      <= ARB_ACCESS;
                    end else if (host_port.req) begin
                        grant_host <= 1'b1;
                        state      <= ARB_ACCESS;
                    end
                end
                ARB_ACCESS: state <= ARB_ACK;
                ARB_ACK: begin
                    // Only the port that owns the grant sees its ack rise
                    stream_ack <= !grant_host;
                    host_ack   <= grant_host;
                    state      <= ARB_RELEASE;
                end
                ARB_RELEASE: begin
                    if (!owner_port.req) begin
                        stream_ack <= 1'b0;
                        host_ack   <= 1'b0;
                        state      <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Read data is held until the next grant reaches ARB_ACK
    always_ff @(posedge clk) begin
        if (state == ARB_ACK) begin
            rdata_q <= ram_rdata;
        end
    end

    assign ram_en    = (state == ARB_ACCESS);
    assign ram_we    = ram_en && (owner_port.cmd.op == MEM_WRITE);
    assign ram_addr  = owner_port.cmd.addr;
    assign ram_wdata = owner_port.cmd.wdata;

    assign stream_rdata = rdata_q;
    assign host_rdata   = rdata_q;

endmodule

`default_nettype wire

//--- hdl/frame_ram.sv
`default_nettype none

module frame_ram (
    input  wire                    clk,
    input  wire                    en,
    input  wire                    we,
    input  wire pov_pkg::slice_t   addr,
    input  wire pov_pkg::led_col_t wdata,
    output pov_pkg::led_col_t      rdata
);
    import pov_pkg::*;

    // One LED column per slice of a full turn
    led_col_t mem [NUM_SLICES];

    // Read-first port, a write returns the column it replaces
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- hdl/pov_top.sv
`default_nettype none

module pov_top #(
    parameter int CLK_HZ   = 66000000,
    parameter int NUM_LEDS = 16
) (
    input  wire                    clk,
    input  wire                    nrst,
    input  wire                    hall_1,
    input  wire                    hall_2,
    input  wire mem_pkg::mem_port_t host_port,
    output logic                   host_ack,
    output pov_pkg::led_col_t      host_rdata,
    output pov_pkg::speed_t        speed_data,
    output logic                   led_sdo,
    output logic                   led_sclk,
    output logic                   led_latch
);
    import pov_pkg::*;
    import mem_pkg::*;

    slice_t    slice_cnt;
    logic      position_sync;
    mem_port_t stream_port;
    logic      stream_ack;
    led_col_t  stream_rdata;
    logic      ram_en;
    logic      ram_we;
    slice_t    ram_addr;
    led_col_t  ram_wdata;
    led_col_t  ram_rdata;

    // Rotor position and speed from the two Hall sensors
    hall_sensor #(
        .CLK_HZ (CLK_HZ)
    ) hall_sensor_i (
        .clk           (clk),
        .nrst          (nrst),
        .hall_1        (hall_1),
        .hall_2        (hall_2),
        .slice_cnt     (slice_cnt),
        .position_sync (position_sync),
        .speed_data    (speed_data)
    );

    // Column fetch on arbiter port 0 and serial output to the LED drivers
    column_streamer #(
        .NUM_LEDS (NUM_LEDS)
    ) column_streamer_i (
        .clk           (clk),
        .nrst          (nrst),
        .slice_cnt     (slice_cnt),
        .position_sync (position_sync),
        .mem_ack       (stream_ack),
        .mem_rdata     (stream_rdata),
        .mem_port      (stream_port),
        .led_sdo       (led_sdo),
        .led_sclk      (led_sclk),
        .led_latch     (led_latch)
    );

    // The host bus enters directly on arbiter port 1
    mem_arbiter mem_arbiter_i (
        .clk          (clk),
        .nrst         (nrst),
        .stream_port  (stream_port),
        .host_port    (host_port),
        .ram_rdata    (ram_rdata),
        .stream_ack   (stream_ack),
        .stream_rdata (stream_rdata),
        .host_ack     (host_ack),
        .host_rdata   (host_rdata),
        .ram_en       (ram_en),
        .ram_we       (ram_we),
        .ram_addr     (ram_addr),
        .ram_wdata    (ram_wdata)
    );

    frame_ram frame_ram_i (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

//--- verif/pov_assert.sv
`default_nettype none

module pov_assert (
    input wire                     clk,
    input wire                     nrst,
    input wire mem_pkg::mem_port_t stream_port,
    input wire mem_pkg::mem_port_t host_port,
    input wire                     stream_ack,
    input wire                     host_ack
);
    timeunit 1ns;
    timeprecision 100ps;

    // Only one port can own the frame memory at a time
    one_owner: assert property (@(posedge clk) disable iff (!nrst)
        !(stream_ack && host_ack))
        else $error("stream_ack and host_ack are high together");

    // Once granted, ack is held until the requester lets go of req
    stream_ack_held: assert property (@(posedge clk) disable iff (!nrst)
        stream_ack && stream_port.req |=> stream_ack)
        else $error("stream_ack fell while stream req was still high");
    host_ack_held: assert property (@(posedge clk) disable iff (!nrst)
        host_ack && host_port.req |=> host_ack)
        else $error("host_ack fell while host req was still high");

    // An ack never rises without a request behind it
    stream_ack_rise: assert property (@(posedge clk) disable iff (!nrst)
        $rose(stream_ack) |-> stream_port.req)
        else $error("stream_ack rose without a stream request");
    host_ack_rise: assert property (@(posedge clk) disable iff (!nrst)
        $rose(host_ack) |-> host_port.req)
        else $error("host_ack rose without a host request");

    // The requester keeps its command steady until the ack arrives
    stream_cmd_stable: assert property (@(posedge clk) disable iff (!nrst)
        stream_port.req && !stream_ack |=> $stable(stream_port.cmd))
        else $error("stream command changed while waiting for stream_ack");
    host_cmd_stable: assert property (@(posedge clk) disable iff (!nrst)
        host_port.req && !host_ack |=> $stable(host_port.cmd))
        else $error("host command changed while waiting for host_ack");

endmodule

`default_nettype wire

//--- verif/pov_tb.sv
`default_nettype none

module pov_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import pov_pkg::*;
    import mem_pkg::*;

    localparam int CLK_HZ     = 66000000;
    localparam int NUM_LEDS   = 16;
    localparam int CLK_PERIOD = 8;
    // Half-turn length in clock cycles, which gives 50 cycles per slice
    localparam int HALF_TURN  = 6400;
    localparam int SLICE_CYCLES = HALF_TURN / SLICES_PER_HALF_TURN;
    localparam longint WATCHDOG_CYCLES = 2 * (12 * HALF_TURN + 256 * 10);
    localparam led_col_t LED_MASK = {{(MAX_LEDS - NUM_LEDS){1'b0}}, {NUM_LEDS{1'b1}}};

    logic      clk = 1'b0;
    logic      nrst;
    logic      hall_1;
    logic      hall_2;
    mem_port_t host_port;
    logic      host_ack;
    led_col_t  host_rdata;
    speed_t    speed_data;
    logic      led_sdo;
    logic      led_sclk;
    logic      led_latch;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] rng_state = 32'ha67;
    logic        next_hall_2 = 1'b0;
    led_col_t    model [NUM_SLICES];
    logic [NUM_LEDS-1:0] rx_shift;
    led_col_t    latched_cols [$];

    pov_top #(
        .CLK_HZ   (CLK_HZ),
        .NUM_LEDS (NUM_LEDS)
    ) pov_top_i (
        .clk        (clk),
        .nrst       (nrst),
        .hall_1     (hall_1),
        .hall_2     (hall_2),
        .host_port  (host_port),
        .host_ack   (host_ack),
        .host_rdata (host_rdata),
        .speed_data (speed_data),
        .led_sdo    (led_sdo),
        .led_sclk   (led_sclk),
        .led_latch  (led_latch)
    );

    // Handshake checks live inside the arbiter
    bind mem_arbiter pov_assert pov_assert_i (
        .clk         (clk),
        .nrst        (nrst),
        .stream_port (stream_port),
        .host_port   (host_port),
        .stream_ack  (stream_ack),
        .host_ack    (host_ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // LED driver model: one bit per high phase of led_sclk, highest LED first
    always @(posedge clk) begin
        if (led_sclk) begin
            rx_shift <= {rx_shift[NUM_LEDS-2:0], led_sdo};
        end
        if (led_latch) begin
            latched_cols.push_back(led_col_t'(rx_shift));
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Random picture column limited to the LEDs that exist
    function automatic led_col_t next_col();
        rng_state = xorshift32(rng_state);
        return led_col_t'(rng_state) & LED_MASK;
    endfunction

    task automatic check_col(input string name, input led_col_t exp, input led_col_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_speed(input string name, input speed_t exp, input speed_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("ERR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // Four-phase write: hold the command until ack, then wait for ack to fall
    task automatic host_write(input slice_t addr, input led_col_t data);
        mem_port_t p;
        p.req       = 1'b1;
        p.cmd.op    = MEM_WRITE;
        p.cmd.addr  = addr;
        p.cmd.wdata = data;
        @(posedge clk);
        host_port <= p;
        do @(posedge clk); while (!host_ack);
        host_port.req <= 1'b0;
        do @(posedge clk); while (host_ack);
    endtask

    // Read data is valid for as long as ack stays high
    task automatic host_read(input slice_t addr, output led_col_t data);
        mem_port_t p;
        p.req       = 1'b1;
        p.cmd.op    = MEM_READ;
        p.cmd.addr  = addr;
        p.cmd.wdata = '0;
        @(posedge clk);
        host_port <= p;
        do @(posedge clk); while (!host_ack);
        data = host_rdata;
        host_port.req <= 1'b0;
        do @(posedge clk); while (host_ack);
    endtask

    // Each half turn starts with a 20-cycle low pulse on its own sensor
    // A crosstalk dip on the other sensor falls inside the guard and must not add a top
    task automatic spin_half_turns(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            if (next_hall_2) hall_2 <= 1'b0;
            else hall_1 <= 1'b0;
            repeat (8) @(posedge clk);
            if (next_hall_2) hall_1 <= 1'b0;
            else hall_2 <= 1'b0;
            repeat (3) @(posedge clk);
            if (next_hall_2) hall_1 <= 1'b1;
            else hall_2 <= 1'b1;
            repeat (9) @(posedge clk);
            hall_1 <= 1'b1;
            hall_2 <= 1'b1;
            repeat (HALF_TURN - 21) @(posedge clk);
            next_hall_2 = !next_hall_2;
        end
    endtask

    // One full turn of latched columns against the model, with an optional skipped range
    task automatic check_turn(input string name, input int skip_lo, input int skip_hi);
        check_count({name, " latch count"}, NUM_SLICES, latched_cols.size());
        for (int s = 0; s < NUM_SLICES && s < latched_cols.size(); s++) begin
            if (s < skip_lo || s > skip_hi) begin
                check_col($sformatf("%s slice %0d", name, s), model[s], latched_cols[s]);
            end
        end
    endtask

    task automatic test_reset_state();
        check_flag("reset host_ack", 1'b0, host_ack);
        check_flag("reset led_latch", 1'b0, led_latch);
        check_flag("reset led_sclk", 1'b0, led_sclk);
        check_flag("reset led_sdo", 1'b0, led_sdo);
        check_speed("reset speed_data", '0, speed_data);
    endtask

    task automatic test_host_access();
        led_col_t rd;
        for (int s = 0; s < NUM_SLICES; s++) begin
            model[s] = next_col();
            host_write(slice_t'(s), model[s]);
        end
        for (int s = 0; s < NUM_SLICES; s++) begin
            host_read(slice_t'(s), rd);
            check_col($sformatf("host read slice %0d", s), model[s], rd);
        end
    endtask

    // The first top after a pause sets a wrong slice period, so one turn settles first
    task automatic test_rotation();
        spin_half_turns(2);
        latched_cols.delete();
        spin_half_turns(1);
        check_count("rotation first half latches", SLICES_PER_HALF_TURN, latched_cols.size());
        spin_half_turns(1);
        check_turn("rotation", 1, 0);
    endtask

    // Tops from the rotation test were exactly one half turn apart
    task automatic test_speed();
        check_speed("speed", speed_t'(CLK_HZ / (2 * HALF_TURN)), speed_data);
    endtask

    task automatic test_live_update();
        int writes_done;
        int writes_in_time;
        writes_done = 0;
        writes_in_time = 0;
        spin_half_turns(2);
        latched_cols.delete();
        fork
            begin
                spin_half_turns(2);
                // Writes that are still stuck behind the streamer miss this count
                writes_in_time = writes_done;
            end
            begin
                // Writes land while the slices near 200 are on display
                repeat (HALF_TURN + 70 * SLICE_CYCLES) @(posedge clk);
                for (int s = 200; s <= 210; s++) begin
                    model[s] = next_col();
                    host_write(slice_t'(s), model[s]);
                    writes_done++;
                end
            end
        join
        check_count("live writes done", 11, writes_in_time);
        check_turn("live turn", 200, 210);
        latched_cols.delete();
        spin_half_turns(2);
        check_turn("after update", 1, 0);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        nrst      = 1'b0;
        hall_1    = 1'b1;
        hall_2    = 1'b1;
        host_port = '0;
        repeat (3) @(posedge clk);
        nrst <= 1'b1;
        @(posedge clk);
        test_reset_state();
        test_host_access();
        test_rotation();
        test_speed();
        test_live_update();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
hdl/pov_pkg.sv
hdl/mem_pkg.sv
hdl/hall_sensor.sv
hdl/column_streamer.sv
hdl/mem_arbiter.sv
hdl/frame_ram.sv
hdl/pov_top.sv
verif/pov_assert.sv
verif/pov_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module pov_tb -f files.f -o pov_sim \
    && ./obj_dir/pov_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx 'ALL CHECKS PASSED' sim.log && echo 'Simulation passed' \
    || { echo 'Simulation failed'; exit 1; }
